// File: verilog/tx_ctrl_pkg.sv
// ----------------------------------------------------------------------
// tx control package
// lane count, buffer depth and run delay constants, plus the packed
// types for timing, control, sample beats and lane status
// ----------------------------------------------------------------------

package tx_ctrl_pkg;

  localparam int LANE_QTY    = 2;   // antenna lanes
  localparam int CP_BLOC_QTY = 10;  // blocks per CP buffer
  localparam int BLOC_CNT_W  = 4;   // width of block counts
  localparam int RUN_DELAY   = 7;   // cycles from enable to run

  // slot timing from the sync block
  typedef struct packed {
    logic [3:0] symbol;
    logic [7:0] slot;
    logic [9:0] frame;
  } sync_time_t;

  // gpio control word, only bit 15 is decoded here
  typedef struct packed {
    logic        enable;     // bit 15
    logic [14:0] reserved;
  } ctrl_word_t;

  // one beat of the processed sample stream
  typedef struct packed {
    logic        valid;
    logic        sop;
    logic        eop;
    logic [1:0]  ante;       // antenna index, meaningful on sop
    logic [15:0] re;
    logic [15:0] im;
  } sample_t;

  // report from one CP insertion buffer
  typedef struct packed {
    logic [BLOC_CNT_W-1:0] used;   // blocks held
    logic                  wr_eop; // block fully written
    logic                  mem_valid;
    logic                  out_valid;
    logic                  out_sop;
    logic                  full;
  } cp_stat_t;

  // per-lane monitor result
  typedef struct packed {
    logic        room;
    logic        underflow;
    logic [31:0] underflow_cnt;
  } lane_res_t;

  // status word towards gpio
  typedef struct packed {
    logic [31:0] transfer_cnt;
    logic [31:0] underflow0_cnt;
    logic [31:0] underflow1_cnt;
    logic        map_underflow_ev;  // sticky
    logic        cp0_full;
    logic        cp1_full;
    logic        cp0_underflow;
    logic        cp1_underflow;
  } status_t;

endpackage

// File: verilog/sync_deglitch.sv
// ----------------------------------------------------------------------
// sync_deglitch
// two capture stages and a held output; the output only takes a value
// seen on two consecutive samples, so one-cycle glitches are dropped
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module sync_deglitch #(
  parameter type payload_t = logic [15:0]
) (
  input  logic     fast_clk,
  input  logic     rst_n,
  input  payload_t din,
  output payload_t dout
);

  payload_t cap1;  // first sample
  payload_t cap2;  // second sample

  always_ff @(posedge fast_clk or negedge rst_n) begin
    if (!rst_n) begin
      cap1 <= '0;
      cap2 <= '0;
    end else begin
      cap1 <= din;
      cap2 <= cap1;
    end
  end

  // hold until two samples agree
  always_ff @(posedge fast_clk or negedge rst_n) begin
    if (!rst_n) begin
      dout <= '0;
    end else if (cap2 == cap1) begin
      dout <= cap2;
    end
  end

endmodule

// File: verilog/local_run_reset.sv
// ----------------------------------------------------------------------
// local_run_reset
// releases the run level a fixed number of cycles after enable, and
// drops it again as soon as enable is cleared
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module local_run_reset
  import tx_ctrl_pkg::*;
(
  input  logic       fast_clk,
  input  logic       rst_n,
  input  ctrl_word_t ctrl,
  output logic       run
);

  logic [2:0] run_cnt;  // saturates at RUN_DELAY

  always_ff @(posedge fast_clk or negedge rst_n) begin
    if (!rst_n) begin
      run_cnt <= 3'd0;
    end else if (!ctrl.enable) begin
      run_cnt <= 3'd0;             // restart on disable
    end else if (run_cnt != 3'(RUN_DELAY)) begin
      run_cnt <= run_cnt + 3'd1;
    end
  end

  assign run = (run_cnt == 3'(RUN_DELAY));

endmodule

// File: verilog/ante_router.sv
// ----------------------------------------------------------------------
// ante_router
// steers each sample beat to the lane named by the antenna index of the
// packet's sop; unselected lanes see an all-zero beat
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module ante_router
  import tx_ctrl_pkg::*;
(
  input  logic    fast_clk,
  input  logic    rst_n,
  input  logic    run,
  input  sample_t proc_in,
  output sample_t lane_out [LANE_QTY]
);

  logic [1:0] ante_q;    // index of the current packet
  logic [1:0] ante_eff;  // index used for this beat
  logic       new_pkt;

  assign new_pkt  = proc_in.valid & proc_in.sop;
  assign ante_eff = new_pkt ? proc_in.ante : ante_q;  // sop beat steers itself

  always_ff @(posedge fast_clk or negedge rst_n) begin
    if (!rst_n) begin
      ante_q <= 2'd0;
    end else if (!run) begin
      ante_q <= 2'd0;
    end else if (new_pkt) begin
      ante_q <= proc_in.ante;
    end
  end

  // index of LANE_QTY or above matches no lane
  always_comb begin
    for (int n = 0; n < LANE_QTY; n++) begin
      if (ante_eff == 2'(n)) begin
        lane_out[n] = proc_in;
      end else begin
        lane_out[n] = '0;
      end
    end
  end

endmodule

// File: verilog/lane_monitor.sv
// ----------------------------------------------------------------------
// lane_monitor
// tracks blocks in flight towards one CP buffer, flags room for another
// block and counts blocks started while the buffer underflows
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module lane_monitor
  import tx_ctrl_pkg::*;
#(
  parameter int LANE = 0
) (
  input  logic       fast_clk,
  input  logic       rst_n,
  input  logic       run,
  input  logic       sched_sop,
  input  logic [1:0] sched_ante,
  input  cp_stat_t   cp_stat,
  output lane_res_t  res
);

  logic [BLOC_CNT_W-1:0] inflight;   // started, not yet in CP buffer
  logic [BLOC_CNT_W:0]   blk_sum;    // inflight + buffered
  logic [31:0]           udf_cnt;
  logic                  blk_start;
  logic                  blk_done;
  logic                  udf;

  assign blk_start = sched_sop & (sched_ante == 2'(LANE));
  assign blk_done  = cp_stat.wr_eop;

  // block credit count
  always_ff @(posedge fast_clk or negedge rst_n) begin
    if (!rst_n) begin
      inflight <= '0;
    end else if (!run) begin
      inflight <= '0;
    end else if (blk_start && !blk_done) begin
      inflight <= inflight + 1'b1;
    end else if (blk_done && !blk_start) begin
      inflight <= inflight - 1'b1;
    end
    // both strobes together leave the count as is
  end

  assign blk_sum = {1'b0, inflight} + {1'b0, cp_stat.used};

  // reading while nothing is stored
  assign udf = cp_stat.out_valid & ~cp_stat.mem_valid;

  always_ff @(posedge fast_clk or negedge rst_n) begin
    if (!rst_n) begin
      udf_cnt <= 32'd0;
    end else if (!run) begin
      udf_cnt <= 32'd0;
    end else if (udf && cp_stat.out_sop) begin
      udf_cnt <= udf_cnt + 32'd1;  // once per output block
    end
  end

  always_comb begin
    res.room          = (blk_sum <= (BLOC_CNT_W + 1)'(CP_BLOC_QTY - 1));
    res.underflow     = udf;
    res.underflow_cnt = udf_cnt;
  end

endmodule

// File: verilog/tx_status.sv
// ----------------------------------------------------------------------
// tx_status
// joins the lane results into the upstream output enable and builds the
// status word with transfer count and sticky map underflow
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tx_status
  import tx_ctrl_pkg::*;
(
  input  logic      fast_clk,
  input  logic      rst_n,
  input  logic      run,
  input  logic      fft_ready,
  input  logic      map_in_eop,
  input  logic      map_empty,
  input  cp_stat_t  cp_stat [LANE_QTY],
  input  lane_res_t lane_res [LANE_QTY],
  output logic      map_out_enable,
  output status_t   status
);

  logic [31:0] transfer_cnt;
  logic        map_udf_ev;
  logic        map_udf;

  // scheduler may start a block only with room in both lanes
  assign map_out_enable = run & fft_ready & lane_res[0].room & lane_res[1].room;

  // both CP buffers starved and nothing left in the map
  assign map_udf = lane_res[0].underflow & lane_res[1].underflow & map_empty;

  always_ff @(posedge fast_clk or negedge rst_n) begin
    if (!rst_n) begin
      transfer_cnt <= 32'd0;
    end else if (!run) begin
      transfer_cnt <= 32'd0;
    end else if (map_in_eop) begin
      transfer_cnt <= transfer_cnt + 32'd1;
    end
  end

  always_ff @(posedge fast_clk or negedge rst_n) begin
    if (!rst_n) begin
      map_udf_ev <= 1'b0;
    end else if (!run) begin
      map_udf_ev <= 1'b0;
    end else if (map_udf) begin
      map_udf_ev <= 1'b1;      // held until disable
    end
  end

  always_comb begin
    status.transfer_cnt     = transfer_cnt;
    status.underflow0_cnt   = lane_res[0].underflow_cnt;
    status.underflow1_cnt   = lane_res[1].underflow_cnt;
    status.map_underflow_ev = map_udf_ev;
    status.cp0_full         = cp_stat[0].full;       // live level
    status.cp1_full         = cp_stat[1].full;
    status.cp0_underflow    = lane_res[0].underflow;
    status.cp1_underflow    = lane_res[1].underflow;
  end

endmodule

// File: verilog/tx_lane_ctrl.sv
// ----------------------------------------------------------------------
// tx_lane_ctrl
// control plane around the transmit datapath: deglitch, run reset,
// antenna steering, per-lane credit and underflow, status word
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tx_lane_ctrl
  import tx_ctrl_pkg::*;
(
  input  logic       fast_clk,
  input  logic       rst_n,
  input  ctrl_word_t gp_control,
  input  sync_time_t sync_time,
  output sync_time_t sync_time_out,
  input  sample_t    proc_in,
  output sample_t    lane_out [LANE_QTY],
  input  logic       sched_sop,
  input  logic [1:0] sched_ante,
  input  logic       map_in_eop,
  input  logic       map_empty,
  input  logic       fft_ready,
  input  cp_stat_t   cp_stat [LANE_QTY],
  output logic       map_out_enable,
  output status_t    status
);

  ctrl_word_t ctrl_dg;              // filtered control word
  logic       run;                  // local run level
  lane_res_t  lane_res [LANE_QTY];

  // slot timing and control word come from another timing source
  sync_deglitch #(
    .payload_t (sync_time_t)
  ) u_time_dg (
    .fast_clk (fast_clk),
    .rst_n    (rst_n),
    .din      (sync_time),
    .dout     (sync_time_out)
  );

  sync_deglitch #(
    .payload_t (ctrl_word_t)
  ) u_ctrl_dg (
    .fast_clk (fast_clk),
    .rst_n    (rst_n),
    .din      (gp_control),
    .dout     (ctrl_dg)
  );

  local_run_reset u_run_rst (
    .fast_clk (fast_clk),
    .rst_n    (rst_n),
    .ctrl     (ctrl_dg),
    .run      (run)
  );

  ante_router u_router (
    .fast_clk (fast_clk),
    .rst_n    (rst_n),
    .run      (run),
    .proc_in  (proc_in),
    .lane_out (lane_out)
  );

  // one monitor per antenna lane
  for (genvar n = 0; n < LANE_QTY; n++) begin : g_lane
    lane_monitor #(
      .LANE (n)
    ) u_lane_mon (
      .fast_clk   (fast_clk),
      .rst_n      (rst_n),
      .run        (run),
      .sched_sop  (sched_sop),
      .sched_ante (sched_ante),
      .cp_stat    (cp_stat[n]),
      .res        (lane_res[n])
    );
  end

  tx_status u_status (
    .fast_clk       (fast_clk),
    .rst_n          (rst_n),
    .run            (run),
    .fft_ready      (fft_ready),
    .map_in_eop     (map_in_eop),
    .map_empty      (map_empty),
    .cp_stat        (cp_stat),
    .lane_res       (lane_res),
    .map_out_enable (map_out_enable),
    .status         (status)
  );

endmodule

// File: verif/tx_lane_ctrl_checker.sv
// ----------------------------------------------------------------------
// tx_lane_ctrl checker
// reference counters built from the top ports, with concurrent
// assertions on deglitch, run reset, steering, credit and status
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tx_lane_ctrl_checker
  import tx_ctrl_pkg::*;
(
  input logic       fast_clk,
  input logic       rst_n,
  input ctrl_word_t gp_control,
  input sync_time_t sync_time,
  input sync_time_t sync_time_out,
  input sample_t    proc_in,
  input sample_t    lane_out [LANE_QTY],
  input logic       sched_sop,
  input logic [1:0] sched_ante,
  input logic       map_in_eop,
  input logic       map_empty,
  input logic       fft_ready,
  input cp_stat_t   cp_stat [LANE_QTY],
  input logic       map_out_enable,
  input status_t    status
);

  int unsigned           fail_cnt = 0;
  logic                  en_c1;
  logic                  en_c2;
  logic                  en_dg;  // enable after two equal samples
  sync_time_t            time_d1;
  sync_time_t            time_d2;  // timing input two samples back
  logic [2:0]            run_cnt;
  logic                  ref_run;
  logic [1:0]            ref_ante;
  logic [1:0]            eff_ante;
  logic [BLOC_CNT_W-1:0] ref_inflight [LANE_QTY];
  logic [31:0]           ref_udf [LANE_QTY];
  logic [31:0]           ref_xfer;
  logic                  ref_map_ev;
  logic                  exp_enable;
  logic [3:0]            exp_flags;  // cp0/cp1 full, cp0/cp1 underflow
  sample_t               exp_lane [LANE_QTY];

  assign ref_run  = (run_cnt == 3'(RUN_DELAY));
  assign eff_ante = (proc_in.valid && proc_in.sop) ? proc_in.ante : ref_ante;

  always_ff @(posedge fast_clk or negedge rst_n) begin
    if (!rst_n) begin
      {en_c1, en_c2, en_dg} <= 3'b000;
      time_d1  <= '0;
      time_d2  <= '0;
      run_cnt  <= 3'd0;
      ref_ante <= 2'd0;
      ref_xfer <= 32'd0;
      ref_map_ev <= 1'b0;
      for (int n = 0; n < LANE_QTY; n++) begin
        ref_inflight[n] <= '0;
        ref_udf[n]      <= 32'd0;
      end
    end else begin
      en_c1 <= gp_control.enable;
      en_c2 <= en_c1;
      if (en_c1 == en_c2) en_dg <= en_c2;
      time_d1 <= sync_time;
      time_d2 <= time_d1;
      if (!en_dg) run_cnt <= 3'd0;
      else if (!ref_run) run_cnt <= run_cnt + 3'd1;
      if (!ref_run) begin
        ref_ante <= 2'd0;
        ref_xfer <= 32'd0;
        ref_map_ev <= 1'b0;
        for (int n = 0; n < LANE_QTY; n++) begin
          ref_inflight[n] <= '0;
          ref_udf[n]      <= 32'd0;
        end
      end else begin
        if (proc_in.valid && proc_in.sop) ref_ante <= proc_in.ante;
        if (map_in_eop) ref_xfer <= ref_xfer + 32'd1;
        if (map_empty && cp_stat[0].out_valid && !cp_stat[0].mem_valid &&
            cp_stat[1].out_valid && !cp_stat[1].mem_valid) ref_map_ev <= 1'b1;
        for (int n = 0; n < LANE_QTY; n++) begin
          if (sched_sop && sched_ante == 2'(n) && !cp_stat[n].wr_eop)
            ref_inflight[n] <= ref_inflight[n] + 1'b1;
          else if (cp_stat[n].wr_eop && !(sched_sop && sched_ante == 2'(n)))
            ref_inflight[n] <= ref_inflight[n] - 1'b1;
          if (cp_stat[n].out_valid && !cp_stat[n].mem_valid && cp_stat[n].out_sop)
            ref_udf[n] <= ref_udf[n] + 32'd1;
        end
      end
    end
  end

  always_comb begin
    exp_enable = ref_run & fft_ready;
    for (int n = 0; n < LANE_QTY; n++) begin
      exp_lane[n] = (eff_ante == 2'(n)) ? proc_in : '0;
      if (({1'b0, ref_inflight[n]} + {1'b0, cp_stat[n].used}) > 5'(CP_BLOC_QTY - 1))
        exp_enable = 1'b0;
    end
    exp_flags = {cp_stat[0].full, cp_stat[1].full,
                 cp_stat[0].out_valid & ~cp_stat[0].mem_valid,
                 cp_stat[1].out_valid & ~cp_stat[1].mem_valid};
  end

  // held value shows up 3 cycles after it is first presented
  a_dg_hold: assert property (@(posedge fast_clk) disable iff (!rst_n)
    sync_time == $past(sync_time) |-> ##2 sync_time_out == $past(sync_time, 2))
    else begin
      fail_cnt++;
      $error("error sync_time_out got %h exp %h",
             $sampled(sync_time_out), $sampled(time_d2));
    end
  a_dg_glitch: assert property (@(posedge fast_clk) disable iff (!rst_n)
    $changed(sync_time_out) |->
      sync_time_out == $past(sync_time, 2) && sync_time_out == $past(sync_time, 3))
    else begin
      fail_cnt++;
      $error("sync_time_out took a value held for one cycle only");
    end
  a_off_zero: assert property (@(posedge fast_clk) disable iff (!rst_n)
    !ref_run && !$past(ref_run) |-> !map_out_enable && status.transfer_cnt == 0 &&
      status.underflow0_cnt == 0 && status.underflow1_cnt == 0 && !status.map_underflow_ev)
    else begin
      fail_cnt++;
      $error("outputs not idle while the run level is low");
    end
  a_lane0: assert property (@(posedge fast_clk) disable iff (!rst_n) lane_out[0] == exp_lane[0])
    else begin
      fail_cnt++;
      $error("error lane_out[0] got %h exp %h", $sampled(lane_out[0]), $sampled(exp_lane[0]));
    end
  a_lane1: assert property (@(posedge fast_clk) disable iff (!rst_n) lane_out[1] == exp_lane[1])
    else begin
      fail_cnt++;
      $error("error lane_out[1] got %h exp %h", $sampled(lane_out[1]), $sampled(exp_lane[1]));
    end
  a_credit: assert property (@(posedge fast_clk) disable iff (!rst_n)
    map_out_enable == exp_enable)
    else begin
      fail_cnt++;
      $error("error map_out_enable got %h exp %h",
             $sampled(map_out_enable), $sampled(exp_enable));
    end
  a_udf: assert property (@(posedge fast_clk) disable iff (!rst_n)
    status.underflow0_cnt == ref_udf[0] && status.underflow1_cnt == ref_udf[1])
    else begin
      fail_cnt++;
      $error("error underflow counts got %h %h exp %h %h",
             $sampled(status.underflow0_cnt), $sampled(status.underflow1_cnt),
             $sampled(ref_udf[0]), $sampled(ref_udf[1]));
    end
  a_map_ev: assert property (@(posedge fast_clk) disable iff (!rst_n)
    status.map_underflow_ev == ref_map_ev)
    else begin
      fail_cnt++;
      $error("error map_underflow_ev got %h exp %h",
             $sampled(status.map_underflow_ev), $sampled(ref_map_ev));
    end
  a_xfer: assert property (@(posedge fast_clk) disable iff (!rst_n)
    status.transfer_cnt == ref_xfer)
    else begin
      fail_cnt++;
      $error("error transfer_cnt got %h exp %h",
             $sampled(status.transfer_cnt), $sampled(ref_xfer));
    end
  // live full and underflow levels in the status word
  a_live: assert property (@(posedge fast_clk) disable iff (!rst_n)
    {status.cp0_full, status.cp1_full, status.cp0_underflow, status.cp1_underflow}
      == exp_flags)
    else begin
      fail_cnt++;
      $error("error status live flags got %h exp %h",
             $sampled({status.cp0_full, status.cp1_full,
                       status.cp0_underflow, status.cp1_underflow}),
             $sampled(exp_flags));
    end

endmodule

bind tx_lane_ctrl tx_lane_ctrl_checker u_chk (.*);

// File: verif/tx_lane_ctrl_tb.sv
// ----------------------------------------------------------------------
// tx_lane_ctrl testbench
// clock, reset and random stimulus; the bound checker does the checking
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tx_lane_ctrl_tb
  import tx_ctrl_pkg::*;
();

  localparam int TEST_CYC  = 8 + 45 + 20 + 41 + 3 * 150 + 10;
  localparam int CYC_LIMIT = TEST_CYC * 3 / 2;

  logic        fast_clk;
  logic        rst_n;
  ctrl_word_t  gp_control;
  sync_time_t  sync_time;
  sync_time_t  sync_time_out;
  sample_t     proc_in;
  sample_t     lane_out [LANE_QTY];
  logic        sched_sop;
  logic [1:0]  sched_ante;
  logic        map_in_eop;
  logic        map_empty;
  logic        fft_ready;
  cp_stat_t    cp_stat [LANE_QTY];
  logic        map_out_enable;
  status_t     status;
  int          seed = 32'h6b9e162f;
  int unsigned prev_fail = 0;
  int          cycle_cnt = 0;

  tx_lane_ctrl i_dut (.*);

  initial begin
    fast_clk = 1'b0;
    forever #10 fast_clk = ~fast_clk;
  end

  always @(posedge fast_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYC_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYC_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  task automatic report(input string name);
    $display("test %s done, %0d new assertion failures", name,
             i_dut.u_chk.fail_cnt - prev_fail);
    prev_fail = i_dut.u_chk.fail_cnt;
  endtask

  // hold values 2 to 4 cycles, each followed by a one-cycle glitch
  task automatic deglitch_test();
    sync_time_t v;
    int         hold;
    for (int i = 0; i < 6; i++) begin
      v    = 22'($random(seed));
      hold = 2 + ($unsigned($random(seed)) % 3);
      @(posedge fast_clk) sync_time <= v;
      repeat (hold - 1) @(posedge fast_clk);
      @(posedge fast_clk) sync_time <= 22'($random(seed));
      @(posedge fast_clk) sync_time <= v;
      @(posedge fast_clk);
    end
  endtask

  task automatic steer_test();
    sample_t    s;
    logic [1:0] a;
    for (int p = 0; p < 8; p++) begin
      a = 2'($random(seed));
      for (int b = 0; b < 5; b++) begin
        s       = '0;
        s.valid = (b < 4);            // last beat is an idle gap
        s.sop   = (b == 0);
        s.eop   = (b == 3);
        s.ante  = (b == 0) ? a : 2'($random(seed));
        s.re    = 16'($random(seed));
        s.im    = 16'($random(seed));
        @(posedge fast_clk) proc_in <= s;
      end
    end
    @(posedge fast_clk) proc_in <= '0;
  endtask

  // random scheduler, map and CP buffer activity at dens percent
  task automatic traffic(input int cycles, input int dens);
    cp_stat_t c;
    for (int t = 0; t < cycles; t++) begin
      @(posedge fast_clk);
      sched_sop  <= ($unsigned($random(seed)) % 100) < dens;
      sched_ante <= 2'($random(seed));
      map_in_eop <= ($unsigned($random(seed)) % 100) < dens;
      map_empty  <= 1'($random(seed));
      fft_ready  <= ($unsigned($random(seed)) % 8) != 0;
      for (int n = 0; n < LANE_QTY; n++) begin
        c           = '0;
        c.used      = 4'($unsigned($random(seed)) % CP_BLOC_QTY);
        c.wr_eop    = ($unsigned($random(seed)) % 100) < dens;
        c.mem_valid = 1'($random(seed));
        c.out_valid = ($unsigned($random(seed)) % 4) != 0;
        c.out_sop   = ($unsigned($random(seed)) % 100) < dens;
        c.full      = 1'($random(seed));
        cp_stat[n] <= c;
      end
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    gp_control = '0;
    sync_time  = '0;
    proc_in    = '0;
    sched_sop  = 1'b0;
    sched_ante = 2'd0;
    map_in_eop = 1'b0;
    map_empty  = 1'b0;
    fft_ready  = 1'b0;
    for (int n = 0; n < LANE_QTY; n++) cp_stat[n] = '0;
    repeat (8) @(posedge fast_clk);
    rst_n <= 1'b1;
    deglitch_test();
    report("deglitch");
    @(posedge fast_clk) gp_control <= {1'b1, 15'($random(seed))};
    fft_ready  <= 1'b1;           // enable held off by run alone
    map_in_eop <= 1'b1;           // transfers before run must not count
    repeat (19) @(posedge fast_clk);
    report("run_reset");
    steer_test();
    report("steering");
    traffic(150, 30);
    report("credit");
    traffic(150, 50);
    report("underflow");
    traffic(150, 20);
    report("transfer");
    @(posedge fast_clk) gp_control.enable <= 1'b0;  // counts must clear
    fft_ready  <= 1'b1;
    map_in_eop <= 1'b1;
    sched_sop  <= 1'b0;
    for (int n = 0; n < LANE_QTY; n++) cp_stat[n] <= '0;
    repeat (9) @(posedge fast_clk);
    report("disable");
    $display("7 tests run, %0d assertion failures", i_dut.u_chk.fail_cnt);
    if (i_dut.u_chk.fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: tx_lane_ctrl.f
verilog/tx_ctrl_pkg.sv
verilog/sync_deglitch.sv
verilog/local_run_reset.sv
verilog/ante_router.sv
verilog/lane_monitor.sv
verilog/tx_status.sv
verilog/tx_lane_ctrl.sv
verif/tx_lane_ctrl_checker.sv
verif/tx_lane_ctrl_tb.sv

// File: Bender.yml
package:
  name: tx_lane_ctrl

sources:
  - verilog/tx_ctrl_pkg.sv
  - verilog/sync_deglitch.sv
  - verilog/local_run_reset.sv
  - verilog/ante_router.sv
  - verilog/lane_monitor.sv
  - verilog/tx_status.sv
  - verilog/tx_lane_ctrl.sv
  - target: simulation
    files:
      - verif/tx_lane_ctrl_checker.sv
      - verif/tx_lane_ctrl_tb.sv
